// ==== fft_pkg.sv ====
`default_nettype none

package fft_pkg;

    // word format, signed fixed point
    localparam int BIT_WIDTH  = 32;
    localparam int DECIMAL_PT = 16;

    // 1.0 in the fixed-point format
    localparam int FIX_ONE = 1 << DECIMAL_PT;

    // complex points per frame
    localparam int N_SAMPLES = 8;

    // butterflies in one stage
    localparam int N_PAIRS = N_SAMPLES / 2;

    // serial side carries all real words, then all imaginary words
    localparam int FRAME_WORDS = 2 * N_SAMPLES;

    // number of DIT stages for this frame size
    localparam int LOG2_N = $clog2(N_SAMPLES);

    // word counter wide enough to reach FRAME_WORDS
    localparam int WORD_IDX_W = $clog2(FRAME_WORDS) + 1;

    typedef logic signed [BIT_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

// ==== twiddle_rom.sv ====
`default_nettype none

module twiddle_rom (
    output fft_pkg::sample_t sine_wave_out [0:fft_pkg::N_SAMPLES-1]
);

    import fft_pkg::*;

    // one period of sin(2*pi*i/N) scaled by 2^DECIMAL_PT and rounded
    // the stage takes cos from the same table a quarter period later
    generate
        case (N_SAMPLES)
            8: begin : g_n8
                assign sine_wave_out[0] = sample_t'(0);
                assign sine_wave_out[1] = sample_t'(46341);
                assign sine_wave_out[2] = sample_t'(FIX_ONE);
                assign sine_wave_out[3] = sample_t'(46341);
                assign sine_wave_out[4] = sample_t'(0);
                assign sine_wave_out[5] = sample_t'(-46341);
                assign sine_wave_out[6] = sample_t'(-FIX_ONE);
                assign sine_wave_out[7] = sample_t'(-46341);
            end
            4: begin : g_n4
                // smaller frame, quarter points only
                assign sine_wave_out[0] = sample_t'(0);
                assign sine_wave_out[1] = sample_t'(FIX_ONE);
                assign sine_wave_out[2] = sample_t'(0);
                assign sine_wave_out[3] = sample_t'(-FIX_ONE);
            end
            2: begin : g_n2
                assign sine_wave_out[0] = sample_t'(0);
                assign sine_wave_out[1] = sample_t'(0);
            end
            default: begin : g_unsupported
                // larger sizes need their own table
                $error("twiddle_rom has no sine table for N_SAMPLES = %0d", N_SAMPLES);
            end
        endcase
    endgenerate

endmodule

`default_nettype wire

// ==== butterfly_unit.sv ====
`default_nettype none

module butterfly_unit (
    input  wire fft_pkg::sample_t a_real,
    input  wire fft_pkg::sample_t a_imag,
    input  wire fft_pkg::sample_t b_real,
    input  wire fft_pkg::sample_t b_imag,
    input  wire fft_pkg::sample_t tw_cos,
    input  wire fft_pkg::sample_t tw_sin,

    output fft_pkg::sample_t top_real,
    output fft_pkg::sample_t top_imag,
    output fft_pkg::sample_t bot_real,
    output fft_pkg::sample_t bot_imag
);

    import fft_pkg::*;

    // full-width products of b with W = cos - i*sin
    logic signed [2*BIT_WIDTH-1:0] prod_rc;
    logic signed [2*BIT_WIDTH-1:0] prod_is;
    logic signed [2*BIT_WIDTH-1:0] prod_ic;
    logic signed [2*BIT_WIDTH-1:0] prod_rs;
    logic signed [2*BIT_WIDTH-1:0] sum_re;
    logic signed [2*BIT_WIDTH-1:0] sum_im;
    sample_t                       wb_real;
    sample_t                       wb_imag;

    assign prod_rc = b_real * tw_cos;
    assign prod_is = b_imag * tw_sin;
    assign prod_ic = b_imag * tw_cos;
    assign prod_rs = b_real * tw_sin;

    // each product drops its fraction bits before the sum
    assign sum_re = (prod_rc >>> DECIMAL_PT) + (prod_is >>> DECIMAL_PT);
    assign sum_im = (prod_ic >>> DECIMAL_PT) - (prod_rs >>> DECIMAL_PT);

    // truncate to the word, no saturation
    assign wb_real = sum_re[BIT_WIDTH-1:0];
    assign wb_imag = sum_im[BIT_WIDTH-1:0];

    // sum and difference wrap at the word width
    assign top_real = a_real + wb_real;
    assign top_imag = a_imag + wb_imag;
    assign bot_real = a_real - wb_real;
    assign bot_imag = a_imag - wb_imag;

endmodule

`default_nettype wire

// ==== deserializer.sv ====
`default_nettype none

module deserializer (
    input  wire              clk,
    input  wire              arst_n,

    input  wire fft_pkg::sample_t recv_msg,
    input  wire              recv_val,
    output logic             recv_rdy,

    output fft_pkg::sample_t send_msg_real [0:fft_pkg::N_SAMPLES-1],
    output fft_pkg::sample_t send_msg_imag [0:fft_pkg::N_SAMPLES-1],
    output logic             send_val,
    input  wire              send_rdy
);

    import fft_pkg::*;

    logic [WORD_IDX_W-1:0] word_cnt;
    logic                  full;
    logic                  last_word;
    logic                  recv_xfer;
    logic                  send_xfer;

    // a full frame blocks input until the stage takes it,
    // but the next frame may start on the very cycle it leaves
    assign recv_rdy  = !full || send_rdy;
    assign send_val  = full;
    assign recv_xfer = recv_val && recv_rdy;
    assign send_xfer = send_val && send_rdy;
    assign last_word = (word_cnt == WORD_IDX_W'(FRAME_WORDS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
            full     <= 1'b0;
        end else begin
            if (recv_xfer) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end

            // counter sits at zero while full, so these never collide
            if (recv_xfer && last_word) begin
                full <= 1'b1;
            end else if (send_xfer) begin
                full <= 1'b0;
            end
        end
    end

    // frame buffer, upper counter half selects the imaginary words
    always_ff @(posedge clk) begin
        if (recv_xfer) begin
            if (word_cnt[LOG2_N]) begin
                send_msg_imag[word_cnt[LOG2_N-1:0]] <= recv_msg;
            end else begin
                send_msg_real[word_cnt[LOG2_N-1:0]] <= recv_msg;
            end
        end
    end

    // an offered frame is neither withdrawn nor overwritten until the stage takes it
    genvar e;
    generate
        for (e = 0; e < N_SAMPLES; e++) begin : g_hold
            a_send_val_held: assert property (
                @(posedge clk) disable iff (!arst_n)
                send_val && !send_rdy |=>
                    send_val && $stable(send_msg_real[e]) && $stable(send_msg_imag[e])
            ) else $error("deserializer dropped or changed its frame before it transferred");
        end
    endgenerate

endmodule

`default_nettype wire

// ==== serializer.sv ====
`default_nettype none

module serializer (
    input  wire              clk,
    input  wire              arst_n,

    input  wire fft_pkg::sample_t recv_msg_real [0:fft_pkg::N_SAMPLES-1],
    input  wire fft_pkg::sample_t recv_msg_imag [0:fft_pkg::N_SAMPLES-1],
    input  wire              recv_val,
    output logic             recv_rdy,

    output fft_pkg::sample_t send_msg,
    output logic             send_val,
    input  wire              send_rdy
);

    import fft_pkg::*;

    sample_t               real_buf [0:N_SAMPLES-1];
    sample_t               imag_buf [0:N_SAMPLES-1];
    logic [WORD_IDX_W-1:0] word_cnt;
    logic                  full;
    logic                  last_word;
    logic                  recv_xfer;
    logic                  send_xfer;

    assign last_word = (word_cnt == WORD_IDX_W'(FRAME_WORDS - 1));

    // reload while the last word goes out, so frames run back to back
    assign recv_rdy  = !full || (send_rdy && last_word);
    assign send_val  = full;
    assign recv_xfer = recv_val && recv_rdy;
    assign send_xfer = send_val && send_rdy;

    // real words first, then imaginary
    assign send_msg = word_cnt[LOG2_N] ? imag_buf[word_cnt[LOG2_N-1:0]]
                                       : real_buf[word_cnt[LOG2_N-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
            full     <= 1'b0;
        end else if (recv_xfer) begin
            word_cnt <= '0;
            full     <= 1'b1;
        end else if (send_xfer) begin
            if (last_word) begin
                word_cnt <= '0;
                full     <= 1'b0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (recv_xfer) begin
            real_buf <= recv_msg_real;
            imag_buf <= recv_msg_imag;
        end
    end

    a_send_msg_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        send_val && !send_rdy |=> send_val && $stable(send_msg)
    ) else $error("serializer changed send_msg under back-pressure");

endmodule

`default_nettype wire

// ==== fft_stage.sv ====
`default_nettype none

module fft_stage #(
    parameter int STAGE_FFT = 0
) (
    input  wire              clk,
    input  wire              arst_n,

    input  wire fft_pkg::sample_t recv_msg_real [0:fft_pkg::N_SAMPLES-1],
    input  wire fft_pkg::sample_t recv_msg_imag [0:fft_pkg::N_SAMPLES-1],
    input  wire              recv_val,
    output logic             recv_rdy,

    output fft_pkg::sample_t send_msg_real [0:fft_pkg::N_SAMPLES-1],
    output fft_pkg::sample_t send_msg_imag [0:fft_pkg::N_SAMPLES-1],
    output logic             send_val,
    input  wire              send_rdy,

    input  wire fft_pkg::sample_t sine_wave_out [0:fft_pkg::N_SAMPLES-1]
);

    import fft_pkg::*;

    sample_t bf_real [0:N_SAMPLES-1];
    sample_t bf_imag [0:N_SAMPLES-1];
    logic    out_full;
    logic    recv_xfer;
    logic    send_xfer;

    // output register may be refilled in the cycle it drains
    assign recv_rdy  = !out_full || send_rdy;
    assign send_val  = out_full;
    assign recv_xfer = recv_val && recv_rdy;
    assign send_xfer = send_val && send_rdy;

    genvar p;
    generate
        for (p = 0; p < N_PAIRS; p++) begin : g_bfly
            // pair p sits in group p/span at offset p%span
            localparam int SPAN    = 1 << STAGE_FFT;
            localparam int POS     = p % SPAN;
            localparam int IDX_TOP = (p / SPAN) * 2 * SPAN + POS;
            localparam int IDX_BOT = IDX_TOP + SPAN;
            // twiddle k, cos read a quarter period ahead
            localparam int TW_SIN  = POS * (N_SAMPLES / (2 * SPAN));
            localparam int TW_COS  = (TW_SIN + N_SAMPLES / 4) % N_SAMPLES;

            butterfly_unit u_bfly (
                .a_real   (recv_msg_real[IDX_TOP]),
                .a_imag   (recv_msg_imag[IDX_TOP]),
                .b_real   (recv_msg_real[IDX_BOT]),
                .b_imag   (recv_msg_imag[IDX_BOT]),
                .tw_cos   (sine_wave_out[TW_COS]),
                .tw_sin   (sine_wave_out[TW_SIN]),
                .top_real (bf_real[IDX_TOP]),
                .top_imag (bf_imag[IDX_TOP]),
                .bot_real (bf_real[IDX_BOT]),
                .bot_imag (bf_imag[IDX_BOT])
            );

            // each pair covers two frame entries, so all entries are watched
            a_out_stable: assert property (
                @(posedge clk) disable iff (!arst_n)
                send_val && !send_rdy |=>
                    $stable(send_msg_real[IDX_TOP]) && $stable(send_msg_imag[IDX_TOP]) &&
                    $stable(send_msg_real[IDX_BOT]) && $stable(send_msg_imag[IDX_BOT])
            ) else $error("fft_stage output changed while stalled");
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_full <= 1'b0;
        end else if (recv_xfer) begin
            out_full <= 1'b1;
        end else if (send_xfer) begin
            out_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (recv_xfer) begin
            send_msg_real <= bf_real;
            send_msg_imag <= bf_imag;
        end
    end

    a_stage_range: assert property (
        @(posedge clk) STAGE_FFT >= 0 && STAGE_FFT < LOG2_N
    ) else $error("STAGE_FFT %0d out of range for N_SAMPLES %0d", STAGE_FFT, N_SAMPLES);

endmodule

`default_nettype wire

// ==== fft_stage_harness.sv ====
`default_nettype none

module fft_stage_harness #(
    parameter int STAGE_FFT = 0
) (
    input  wire              clk,
    input  wire              arst_n,

    input  wire fft_pkg::sample_t recv_msg,
    input  wire              recv_val,
    output logic             recv_rdy,

    output fft_pkg::sample_t send_msg,
    output logic             send_val,
    input  wire              send_rdy
);

    import fft_pkg::*;

    sample_t sine_wave  [0:N_SAMPLES-1];

    // deserializer to stage
    sample_t deser_real [0:N_SAMPLES-1];
    sample_t deser_imag [0:N_SAMPLES-1];
    logic    deser_val;
    logic    deser_rdy;

    // stage to serializer
    sample_t stage_real [0:N_SAMPLES-1];
    sample_t stage_imag [0:N_SAMPLES-1];
    logic    stage_val;
    logic    stage_rdy;

    twiddle_rom twiddle_rom_inst (
        .sine_wave_out (sine_wave)
    );

    deserializer deserializer_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .recv_msg      (recv_msg),
        .recv_val      (recv_val),
        .recv_rdy      (recv_rdy),
        .send_msg_real (deser_real),
        .send_msg_imag (deser_imag),
        .send_val      (deser_val),
        .send_rdy      (deser_rdy)
    );

    fft_stage #(
        .STAGE_FFT (STAGE_FFT)
    ) fft_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .recv_msg_real (deser_real),
        .recv_msg_imag (deser_imag),
        .recv_val      (deser_val),
        .recv_rdy      (deser_rdy),
        .send_msg_real (stage_real),
        .send_msg_imag (stage_imag),
        .send_val      (stage_val),
        .send_rdy      (stage_rdy),
        .sine_wave_out (sine_wave)
    );

    serializer serializer_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .recv_msg_real (stage_real),
        .recv_msg_imag (stage_imag),
        .recv_val      (stage_val),
        .recv_rdy      (stage_rdy),
        .send_msg      (send_msg),
        .send_val      (send_val),
        .send_rdy      (send_rdy)
    );

endmodule

`default_nettype wire

// ==== tb_fft_stage_harness.sv ====
`default_nettype none

module tb_fft_stage_harness;

    timeunit 1ns;
    timeprecision 1ps;

    import fft_pkg::*;

    localparam int TB_STAGE    = 2;
    localparam int N_ROWS      = 6;
    localparam int CYCLE_LIMIT = N_ROWS * FRAME_WORDS * 4 + 200;

    logic    clk = 1'b0;
    logic    arst_n = 1'b0;
    sample_t recv_msg = '0;
    logic    recv_val = 1'b0;
    logic    recv_rdy;
    sample_t send_msg;
    logic    send_val;
    logic    send_rdy = 1'b0;

    // rows: 0 impulse, 1 ones, 2 alternating, 3 wrapping, 4 and 5 random
    sample_t     stim_real [N_ROWS][N_SAMPLES];
    sample_t     stim_imag [N_ROWS][N_SAMPLES];
    sample_t     exp_real  [N_ROWS][N_SAMPLES];
    sample_t     exp_imag  [N_ROWS][N_SAMPLES];
    logic [15:0] val_pat   [N_ROWS];
    logic [15:0] rdy_pat   [N_ROWS];
    logic        lat_chk   [N_ROWS];

    sample_t     exp_q [$];
    logic [31:0] lfsr_state = 32'h2cff;
    logic        lat_armed = 1'b0;
    int          cycle = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    fft_stage_harness #(
        .STAGE_FFT (TB_STAGE)
    ) fft_stage_harness_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .recv_msg (recv_msg),
        .recv_val (recv_val),
        .recv_rdy (recv_rdy),
        .send_msg (send_msg),
        .send_val (send_val),
        .send_rdy (send_rdy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            other_errors++;
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("error count: %0d value errors, %0d other errors",
                     value_errors, other_errors);
            $display("sim failed");
            $finish;
        end
    end

    // galois form, one step per bit taken
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = out ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // sin(2*pi*i/8) scaled by 65536
    function automatic sample_t sine_entry(input int idx);
        case (idx)
            1, 3:    sine_entry = 46341;
            2:       sine_entry = 65536;
            5, 7:    sine_entry = -46341;
            6:       sine_entry = -65536;
            default: sine_entry = 0;
        endcase
    endfunction

    // reference butterfly pass, W = cos - i*sin
    task automatic model_row(input int r);
        int      span;
        int      k;
        sample_t c;
        sample_t s;
        sample_t br;
        sample_t bi;
        sample_t wr;
        sample_t wi;
        longint  acc;
        span = 1 << TB_STAGE;
        for (int j = 0; j < N_SAMPLES; j++) begin
            if ((j & span) == 0) begin
                k  = (j % span) * (N_SAMPLES / (2 * span));
                c  = sine_entry((k + N_SAMPLES / 4) % N_SAMPLES);
                s  = sine_entry(k);
                br = stim_real[r][j + span];
                bi = stim_imag[r][j + span];
                acc = ((longint'(br) * longint'(c)) >>> 16)
                    + ((longint'(bi) * longint'(s)) >>> 16);
                wr  = acc[31:0];
                acc = ((longint'(bi) * longint'(c)) >>> 16)
                    - ((longint'(br) * longint'(s)) >>> 16);
                wi  = acc[31:0];
                exp_real[r][j]        = stim_real[r][j] + wr;
                exp_imag[r][j]        = stim_imag[r][j] + wi;
                exp_real[r][j + span] = stim_real[r][j] - wr;
                exp_imag[r][j + span] = stim_imag[r][j] - wi;
            end
        end
    endtask

    task automatic build_table();
        for (int r = 0; r < N_ROWS; r++) begin
            val_pat[r] = 16'hffff;
            rdy_pat[r] = 16'hffff;
            lat_chk[r] = (r == 0);
            for (int i = 0; i < N_SAMPLES; i++) begin
                case (r)
                    0: begin
                        stim_real[r][i] = (i == 0) ? 65536 : 0;
                        stim_imag[r][i] = 0;
                    end
                    1: begin
                        stim_real[r][i] = 65536;
                        stim_imag[r][i] = 65536;
                    end
                    2: begin
                        stim_real[r][i] = (i % 2 == 0) ? 65536 * (i + 1) : -65536 * (i + 1);
                        stim_imag[r][i] = (i % 2 == 0) ? -32768 * (i + 1) : 32768 * (i + 1);
                    end
                    3: begin
                        stim_real[r][i] = 32'sh7ff0_0000 + i;
                        stim_imag[r][i] = -32'sh7ff0_0000 - i;
                    end
                    default: begin
                        stim_real[r][i] = random_bits(32);
                        stim_imag[r][i] = random_bits(32);
                    end
                endcase
            end
            model_row(r);
        end
        // stalls on both sides
        // random patterns keep bit 0 set so none is all low
        rdy_pat[2] = 16'b1101_1011_0111_1110;
        val_pat[3] = 16'b1011_1110_1101_1111;
        rdy_pat[4] = 16'(random_bits(16)) | 16'h0001;
        val_pat[5] = 16'(random_bits(16)) | 16'h0001;
        rdy_pat[5] = 16'(random_bits(16)) | 16'h0001;
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t want);
        if (got !== want) begin
            value_errors++;
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic produce_frames();
        logic [3:0] tick;
        logic       pending;
        int         w;
        tick = '0;
        pending = 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            w = 0;
            while (w < FRAME_WORDS) begin
                @(posedge clk);
                #0.5;
                // an offered word stays until it is taken
                recv_val = pending || val_pat[r][tick];
                recv_msg = (w < N_SAMPLES) ? stim_real[r][w] : stim_imag[r][w - N_SAMPLES];
                tick++;
                @(negedge clk);
                pending = recv_val && !recv_rdy;
                if (recv_val && recv_rdy) begin
                    if (w == FRAME_WORDS - 1) begin
                        for (int i = 0; i < N_SAMPLES; i++) begin
                            exp_q.push_back(exp_real[r][i]);
                        end
                        for (int i = 0; i < N_SAMPLES; i++) begin
                            exp_q.push_back(exp_imag[r][i]);
                        end
                        lat_armed = lat_armed || lat_chk[r];
                    end
                    w++;
                end
            end
        end
        @(posedge clk);
        #0.5;
        recv_val = 1'b0;
    endtask

    task automatic consume_frames();
        logic [3:0] tick;
        tick = '0;
        for (int r = 0; r < N_ROWS; r++) begin
            for (int w = 0; w < FRAME_WORDS; w++) begin
                do begin
                    @(posedge clk);
                    #0.5;
                    send_rdy = rdy_pat[r][tick];
                    tick++;
                    @(negedge clk);
                end while (!(send_val && send_rdy));
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("output word %0d of frame %0d came out before its frame went in", w, r);
                end else begin
                    check_sample($sformatf("send_msg frame %0d word %0d", r, w), send_msg,
                                 exp_q.pop_front());
                end
            end
        end
        @(posedge clk);
        #0.5;
        send_rdy = 1'b1;
    endtask

    // send_val of word 0 rises three cycles after the last input transfer
    task automatic watch_latency();
        wait (lat_armed);
        repeat (2) begin
            @(negedge clk);
            check_flag("send_val", send_val, 1'b0);
        end
        @(negedge clk);
        check_flag("send_val", send_val, 1'b1);
    endtask

    initial begin
        build_table();
        repeat (5) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("recv_rdy", recv_rdy, 1'b1);
        check_flag("send_val", send_val, 1'b0);
        fork
            produce_frames();
            consume_frames();
            watch_latency();
        join
        // extra or repeated words would show up here
        repeat (4) @(negedge clk);
        check_flag("send_val", send_val, 1'b0);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected output words never came out", exp_q.size());
        end
        $display("error count: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
fft_pkg.sv
twiddle_rom.sv
butterfly_unit.sv
deserializer.sv
serializer.sv
fft_stage.sv
fft_stage_harness.sv
tb_fft_stage_harness.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the FFT stage testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_fft_stage_harness -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -qx "sim passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
